// File: Bender.yml
package:
  name: peripheralBus

sources:
  - busPkg.sv
  - periphPkg.sv
  - busDecode.sv
  - lfsrUnit.sv
  - stopwatchUnit.sv
  - hexDisplay.sv
  - readReturn.sv
  - peripheralBus.sv
  - target: test
    files:
      - peripheralBusChecker.sv
      - tbPeripheralBus.sv

// File: busDecode.sv
// Stage one of the peripheral bus pipeline.
// Decodes the word address against the map and registers the
// target select, the strobes and the write payload.
`timescale 1ns/1ns
`default_nettype none

module busDecode import busPkg::*; (
    input  logic      iCLK,
    input  logic      arstN,
    input  logic      readEnable,
    input  logic      writeEnable,
    input  byteEnT    byteEnable,
    input  busAddrT   address,
    input  busDataT   writeData,
    output periphSelT reqSel,
    output logic      reqRead,
    output logic      reqWrite,
    output byteEnT    reqByteEn,
    output busDataT   reqWriteData
);

    periphSelT decodedSel;

    // word compare, byte offset ignored
    always_comb begin
        if (address[31:2] == lfsrAddr[31:2]) begin
            decodedSel = selLfsr;
        end else if (address[31:2] == stopwatchAddr[31:2]) begin
            decodedSel = selStopwatch;
        end else if (address[31:2] == displayAddr[31:2]) begin
            decodedSel = selDisplay;
        end else begin
            decodedSel = selNone;
        end
    end

    // control half of the request register
    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            reqSel   <= selNone;
            reqRead  <= 1'b0;
            reqWrite <= 1'b0;
        end else begin
            reqSel   <= decodedSel;
            reqRead  <= readEnable;
            reqWrite <= writeEnable;
        end
    end

    // payload, only meaningful alongside reqWrite
    always_ff @(posedge iCLK) begin
        reqByteEn    <= byteEnable;
        reqWriteData <= writeData;
    end

endmodule

`default_nettype wire

// File: busPkg.sv
// Data bus definitions for the peripheral pipeline.
// Holds the bus widths, the peripheral address map and the
// select encoding that stage one hands to the peripherals.
`default_nettype none

package busPkg;

    // byte address and data word of the shared data bus
    typedef logic [31:0] busAddrT;
    typedef logic [31:0] busDataT;

    // one enable per data byte, bit 0 is the low byte
    typedef logic [3:0] byteEnT;

    // target of a registered request
    typedef enum logic [1:0] {
        selNone      = 2'd0,
        selLfsr      = 2'd1,
        selStopwatch = 2'd2,
        selDisplay   = 2'd3
    } periphSelT;

    // memory map, word aligned
    // decode looks at bits 31..2 only
    localparam busAddrT lfsrAddr      = 32'hFF20_0250;
    localparam busAddrT stopwatchAddr = 32'hFF20_0510;
    localparam busAddrT displayAddr   = 32'hFF20_0020;

endpackage

`default_nettype wire

// File: hexDisplay.sv
// Seven-segment display peripheral.
// A bus-writable 32-bit register, merged byte by byte, whose six
// low nibbles drive six active-low digits through a lookup table.
`timescale 1ns/1ns
`default_nettype none

module hexDisplay import busPkg::*, periphPkg::*; (
    input  logic      iCLK,
    input  logic      arstN,
    input  periphSelT reqSel,
    input  logic      reqWrite,
    input  byteEnT    reqByteEn,
    input  busDataT   reqWriteData,
    output busDataT   displayValue,
    output segmentT   hexSegments0,
    output segmentT   hexSegments1,
    output segmentT   hexSegments2,
    output segmentT   hexSegments3,
    output segmentT   hexSegments4,
    output segmentT   hexSegments5
);

    busDataT displayReg;
    segmentT digitSeg [digitCount];

    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            displayReg <= '0;
        end else if (reqWrite && (reqSel == selDisplay)) begin
            // untouched bytes keep their old value
            for (int b = 0; b < 4; b++) begin
                if (reqByteEn[b]) begin
                    displayReg[8*b +: 8] <= reqWriteData[8*b +: 8];
                end
            end
        end
    end

    // digit k shows nibble k
    for (genvar k = 0; k < digitCount; k++) begin : gDigit
        nibbleT digitNibble;
        assign digitNibble = displayReg[4*k +: 4];
        assign digitSeg[k] = segmentTable[digitNibble];
    end

    // top two nibbles are readable but not shown
    assign displayValue = displayReg;

    assign hexSegments0 = digitSeg[0];
    assign hexSegments1 = digitSeg[1];
    assign hexSegments2 = digitSeg[2];
    assign hexSegments3 = digitSeg[3];
    assign hexSegments4 = digitSeg[4];
    assign hexSegments5 = digitSeg[5];

endmodule

`default_nettype wire

// File: lfsrUnit.sv
// Galois LFSR random-number peripheral.
// A read returns the current state and steps it once; a write
// seeds the enabled bytes, with a zero seed forced to one.
`timescale 1ns/1ns
`default_nettype none

module lfsrUnit import busPkg::*, periphPkg::*; (
    input  logic      iCLK,
    input  logic      arstN,
    input  periphSelT reqSel,
    input  logic      reqRead,
    input  logic      reqWrite,
    input  byteEnT    reqByteEn,
    input  busDataT   reqWriteData,
    output busDataT   lfsrValue
);

    busDataT state;
    busDataT stepped;
    busDataT merged;

    // one galois step, shift right and fold the taps back in
    assign stepped = {1'b0, state[31:1]} ^ (state[0] ? lfsrTaps : 32'h0);

    // seed value, enabled bytes replaced
    always_comb begin
        merged = state;
        for (int b = 0; b < 4; b++) begin
            if (reqByteEn[b]) begin
                merged[8*b +: 8] = reqWriteData[8*b +: 8];
            end
        end
    end

    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            state <= 32'd1;
        end else if (reqSel == selLfsr) begin
            if (reqWrite) begin
                // all-zero state would lock up the sequence
                state <= (merged == 32'h0) ? 32'd1 : merged;
            end else if (reqRead) begin
                state <= stepped;
            end
        end
    end

    // pre-step value, captured by stage three on the same edge
    assign lfsrValue = state;

endmodule

`default_nettype wire

// File: periphPkg.sv
// Peripheral definitions shared by the LFSR and display blocks.
// Segment and nibble types, the LFSR feedback mask and the
// active-low seven-segment lookup table.
`default_nettype none

package periphPkg;

    // segments a..g in bits 0..6, low turns a segment on
    typedef logic [6:0] segmentT;

    // one hex digit
    typedef logic [3:0] nibbleT;

    // galois mask for x^32 + x^22 + x^2 + x + 1, right-shift form
    localparam logic [31:0] lfsrTaps = 32'h8020_0003;

    // digits on the board
    localparam int digitCount = 6;

    // patterns for 0..F, index is the nibble value
    localparam segmentT segmentTable [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30,
        7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03,
        7'h46, 7'h21, 7'h06, 7'h0E
    };

endpackage

`default_nettype wire

// File: peripheralBus.f
busPkg.sv
periphPkg.sv
busDecode.sv
lfsrUnit.sv
stopwatchUnit.sv
hexDisplay.sv
readReturn.sv
peripheralBus.sv
peripheralBusChecker.sv
tbPeripheralBus.sv

// File: peripheralBus.sv
// Top level of the memory-mapped peripheral bus.
// Stage one registers and decodes the request, stage two is the
// LFSR, stopwatch and display peripherals, stage three registers
// the read data back onto the bus.
`timescale 1ns/1ns
`default_nettype none

module peripheralBus import busPkg::*, periphPkg::*; #(
    parameter int unsigned ticksPerMs = 50000
) (
    input  logic    iCLK,
    input  logic    arstN,
    input  logic    readEnable,
    input  logic    writeEnable,
    input  byteEnT  byteEnable,
    input  busAddrT address,
    input  busDataT writeData,
    output busDataT readData,
    output segmentT hexSegments0,
    output segmentT hexSegments1,
    output segmentT hexSegments2,
    output segmentT hexSegments3,
    output segmentT hexSegments4,
    output segmentT hexSegments5
);

    // registered request, fanned out to every peripheral
    periphSelT reqSel;
    logic      reqRead;
    logic      reqWrite;
    byteEnT    reqByteEn;
    busDataT   reqWriteData;

    // current peripheral values
    busDataT lfsrValue;
    busDataT stopwatchMs;
    busDataT displayValue;

    busDecode busDecode_i (
        .iCLK         (iCLK),
        .arstN        (arstN),
        .readEnable   (readEnable),
        .writeEnable  (writeEnable),
        .byteEnable   (byteEnable),
        .address      (address),
        .writeData    (writeData),
        .reqSel       (reqSel),
        .reqRead      (reqRead),
        .reqWrite     (reqWrite),
        .reqByteEn    (reqByteEn),
        .reqWriteData (reqWriteData)
    );

    lfsrUnit lfsrUnit_i (
        .iCLK         (iCLK),
        .arstN        (arstN),
        .reqSel       (reqSel),
        .reqRead      (reqRead),
        .reqWrite     (reqWrite),
        .reqByteEn    (reqByteEn),
        .reqWriteData (reqWriteData),
        .lfsrValue    (lfsrValue)
    );

    stopwatchUnit #(
        .ticksPerMs (ticksPerMs)
    ) stopwatchUnit_i (
        .iCLK        (iCLK),
        .arstN       (arstN),
        .reqSel      (reqSel),
        .reqWrite    (reqWrite),
        .stopwatchMs (stopwatchMs)
    );

    hexDisplay hexDisplay_i (
        .iCLK         (iCLK),
        .arstN        (arstN),
        .reqSel       (reqSel),
        .reqWrite     (reqWrite),
        .reqByteEn    (reqByteEn),
        .reqWriteData (reqWriteData),
        .displayValue (displayValue),
        .hexSegments0 (hexSegments0),
        .hexSegments1 (hexSegments1),
        .hexSegments2 (hexSegments2),
        .hexSegments3 (hexSegments3),
        .hexSegments4 (hexSegments4),
        .hexSegments5 (hexSegments5)
    );

    readReturn readReturn_i (
        .iCLK         (iCLK),
        .arstN        (arstN),
        .reqSel       (reqSel),
        .reqRead      (reqRead),
        .lfsrValue    (lfsrValue),
        .stopwatchMs  (stopwatchMs),
        .displayValue (displayValue),
        .readData     (readData)
    );

endmodule

`default_nettype wire

// File: peripheralBusChecker.sv
// Bus protocol and output checks for the peripheral bus top.
// Bound into every peripheralBus instance.
`timescale 1ns/1ns
`default_nettype none

module peripheralBusChecker import busPkg::*, periphPkg::*; (
    input logic    iCLK,
    input logic    arstN,
    input logic    readEnable,
    input logic    writeEnable,
    input busDataT readData,
    input segmentT hexSegments0,
    input segmentT hexSegments1,
    input segmentT hexSegments2,
    input segmentT hexSegments3,
    input segmentT hexSegments4,
    input segmentT hexSegments5
);

    // failures seen so far, read by the testbench at the end
    int failCount = 0;

    // master must never strobe both
    exclusiveStrobes: assert property (@(posedge iCLK) disable iff (!arstN)
        !(readEnable && writeEnable))
        else begin
            failCount++;
            $error("readEnable and writeEnable high together");
        end

    // read sampled at N updates readData at N+1, nothing else moves it
    readDataHolds: assert property (@(posedge iCLK) disable iff (!arstN)
        !$past(readEnable, 2) |-> $stable(readData))
        else begin
            failCount++;
            $error("readData changed without a read");
        end

    digitsKnown: assert property (@(posedge iCLK) disable iff (!arstN)
        !$isunknown({hexSegments5, hexSegments4, hexSegments3,
                     hexSegments2, hexSegments1, hexSegments0}))
        else begin
            failCount++;
            $error("display digit unknown");
        end

endmodule

bind peripheralBus peripheralBusChecker peripheralBusChecker_i (.*);

`default_nettype wire

// File: readReturn.sv
// Stage three of the peripheral bus pipeline.
// Picks the addressed peripheral value on a registered read and
// holds it on readData until the next read completes.
`timescale 1ns/1ns
`default_nettype none

module readReturn import busPkg::*; (
    input  logic      iCLK,
    input  logic      arstN,
    input  periphSelT reqSel,
    input  logic      reqRead,
    input  busDataT   lfsrValue,
    input  busDataT   stopwatchMs,
    input  busDataT   displayValue,
    output busDataT   readData
);

    busDataT selected;

    // unmapped reads come back as zero
    always_comb begin
        unique case (reqSel)
            selLfsr:      selected = lfsrValue;
            selStopwatch: selected = stopwatchMs;
            selDisplay:   selected = displayValue;
            default:      selected = '0;
        endcase
    end

    // level output, only a read updates it
    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            readData <= '0;
        end else if (reqRead) begin
            readData <= selected;
        end
    end

endmodule

`default_nettype wire

// File: stopwatchUnit.sv
// Millisecond stopwatch peripheral.
// A prescaler divides the clock down to one tick per millisecond
// and a 32-bit counter accumulates the ticks. Any bus write to the
// stopwatch restarts both.
`timescale 1ns/1ns
`default_nettype none

module stopwatchUnit import busPkg::*; #(
    parameter int unsigned ticksPerMs = 50000
) (
    input  logic      iCLK,
    input  logic      arstN,
    input  periphSelT reqSel,
    input  logic      reqWrite,
    output busDataT   stopwatchMs
);

    // wide enough for ticksPerMs - 1, at least one bit
    localparam int PreW = (ticksPerMs > 1) ? $clog2(ticksPerMs) : 1;

    logic [PreW-1:0] prescaler;
    busDataT         msCount;
    logic            msTick;
    logic            clearReq;

    // last cycle of the current millisecond
    assign msTick = (prescaler == PreW'(ticksPerMs - 1));

    // write data is don't-care, the strobe alone restarts
    assign clearReq = reqWrite && (reqSel == selStopwatch);

    always_ff @(posedge iCLK or negedge arstN) begin
        if (!arstN) begin
            prescaler <= '0;
            msCount   <= '0;
        end else if (clearReq) begin
            prescaler <= '0;
            msCount   <= '0;
        end else if (msTick) begin
            prescaler <= '0;
            msCount   <= msCount + 32'd1;
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

    // count wraps silently after 2^32 ms
    assign stopwatchMs = msCount;

endmodule

`default_nettype wire

// File: tbPeripheralBus.sv
// Testbench for the peripheral bus pipeline.
// Drives random LFSR, display, stopwatch and unmapped traffic from a
// fixed-seed LFSR and checks readData and the digits against a model.
`timescale 1ns/1ns
`default_nettype none

module tbPeripheralBus import busPkg::*, periphPkg::*; ();

    localparam int clkPeriod = 40;
    localparam int tbTicksPerMs = 8;
    localparam int seedRounds = 6;
    localparam int readsPerSeed = 16;
    localparam int displayRounds = 20;
    localparam int stopwatchRounds = 4;
    localparam int unmappedRounds = 12;
    // per-test cycle counts, worst case waits, plus slack
    localparam int budgetCycles = 3 + 3 + (seedRounds + 1) * (1 + readsPerSeed) + 2
        + displayRounds * 4 + stopwatchRounds * 76 + unmappedRounds * 4 + 2 + 50;
    // stimulus generator, unrelated to the DUT polynomial
    localparam logic [31:0] rngTaps = 32'hB4BC_D35C;

    logic    iCLK;
    logic    arstN;
    logic    readEnable;
    logic    writeEnable;
    byteEnT  byteEnable;
    busAddrT address;
    busDataT writeData;
    busDataT readData;
    segmentT hexSegments0;
    segmentT hexSegments1;
    segmentT hexSegments2;
    segmentT hexSegments3;
    segmentT hexSegments4;
    segmentT hexSegments5;

    logic [31:0] rngState = 32'h813d_e218;
    busDataT     modelLfsr = 32'd1;
    busDataT     modelDisplay = '0;
    busDataT     heldData = '0;
    int          heldSlack = 0;
    int          cycleCount = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    // pending reads, in issue order
    int          dueQ [$];
    busDataT     expectQ [$];
    int          slackQ [$];

    peripheralBus #(
        .ticksPerMs (tbTicksPerMs)
    ) peripheralBus_i (
        .iCLK         (iCLK),
        .arstN        (arstN),
        .readEnable   (readEnable),
        .writeEnable  (writeEnable),
        .byteEnable   (byteEnable),
        .address      (address),
        .writeData    (writeData),
        .readData     (readData),
        .hexSegments0 (hexSegments0),
        .hexSegments1 (hexSegments1),
        .hexSegments2 (hexSegments2),
        .hexSegments3 (hexSegments3),
        .hexSegments4 (hexSegments4),
        .hexSegments5 (hexSegments5)
    );

    initial begin
        iCLK = 1'b0;
        forever #(clkPeriod / 2) iCLK = ~iCLK;
    end

    // n generator steps, one bit taken per step
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], rngState[0]};
            rngState = rngState[0] ? ((rngState >> 1) ^ rngTaps) : (rngState >> 1);
        end
        return value;
    endfunction

    // x^32 + x^22 + x^2 + x + 1, right-shifting galois form
    function automatic busDataT lfsrModelStep(input busDataT s);
        busDataT mask;
        mask = (32'd1 << 31) | (32'd1 << 21) | (32'd1 << 1) | 32'd1;
        return s[0] ? ((s >> 1) ^ mask) : (s >> 1);
    endfunction

    function automatic busDataT mergeBytes(input busDataT old, input busDataT data,
                                           input byteEnT be);
        busDataT result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) result[8*b +: 8] = data[8*b +: 8];
        end
        return result;
    endfunction

    // lit segments gfedcba, inverted for the board
    function automatic segmentT segmentsFor(input nibbleT n);
        logic [6:0] lit;
        case (n)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    // same word, random byte offset
    function automatic busAddrT anyOffset(input busAddrT addr);
        return {addr[31:2], 2'(randomBits(2))};
    endfunction

    function automatic busAddrT unmappedAddr();
        busAddrT a;
        a = randomBits(32);
        while (a[31:2] == lfsrAddr[31:2] || a[31:2] == stopwatchAddr[31:2]
               || a[31:2] == displayAddr[31:2]) begin
            a = a + 32'd4;
        end
        return a;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected, input int slack);
        logic [31:0] diff;
        checkCount++;
        diff = (actual > expected) ? actual - expected : expected - actual;
        if ($isunknown(actual) || diff > slack) begin
            errorCount++;
            $display("MISMATCH %s at %0t: got %h, expected %h", name, $time, actual, expected);
        end
    endtask

    // readData changes only when a read comes due, else it must hold
    task automatic trackReadData();
        if (dueQ.size() > 0 && dueQ[0] == cycleCount) begin
            heldData = expectQ.pop_front();
            heldSlack = slackQ.pop_front();
            void'(dueQ.pop_front());
        end
        checkValue("readData", readData, heldData, heldSlack);
    endtask

    // called at a falling edge, returns at the next one
    task automatic busCycle(input logic rd, input logic wr, input byteEnT be,
                            input busAddrT addr, input busDataT data,
                            input busDataT expected, input int slack);
        readEnable = rd;
        writeEnable = wr;
        byteEnable = be;
        address = addr;
        writeData = data;
        if (rd) begin
            // registered at the next edge, on readData one edge later
            dueQ.push_back(cycleCount + 2);
            expectQ.push_back(expected);
            slackQ.push_back(slack);
        end
        @(negedge iCLK);
        cycleCount++;
        trackReadData();
    endtask

    task automatic readReg(input busAddrT addr, input busDataT expected, input int slack);
        busCycle(1'b1, 1'b0, '0, addr, '0, expected, slack);
    endtask

    task automatic writeReg(input busAddrT addr, input byteEnT be, input busDataT data);
        busCycle(1'b0, 1'b1, be, addr, data, '0, 0);
    endtask

    task automatic idle(input int n);
        repeat (n) busCycle(1'b0, 1'b0, '0, '0, '0, '0, 0);
    endtask

    task automatic checkDigits();
        segmentT shown [digitCount];
        shown[0] = hexSegments0;
        shown[1] = hexSegments1;
        shown[2] = hexSegments2;
        shown[3] = hexSegments3;
        shown[4] = hexSegments4;
        shown[5] = hexSegments5;
        for (int k = 0; k < digitCount; k++) begin
            checkValue($sformatf("hexSegments%0d", k), 32'(shown[k]),
                       32'(segmentsFor(modelDisplay[4*k +: 4])), 0);
        end
    endtask

    initial begin
        #(budgetCycles * clkPeriod);
        $display("watchdog expired after %0d cycles, test sequence did not finish",
                 budgetCycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        byteEnT  be;
        busDataT data;
        busDataT merged;
        int      waitCycles;
        int      failTotal;
        readEnable = 1'b0;
        writeEnable = 1'b0;
        byteEnable = '0;
        address = '0;
        writeData = '0;
        arstN = 1'b0;
        repeat (3) @(posedge iCLK);
        @(negedge iCLK);
        arstN = 1'b1;

        // reset state, first lfsr read gives the reset value
        checkValue("readData", readData, 32'h0, 0);
        checkDigits();
        readReg(anyOffset(lfsrAddr), 32'd1, 0);
        modelLfsr = lfsrModelStep(modelLfsr);
        idle(2);

        // random seeds, last round an all-zero seed
        for (int r = 0; r <= seedRounds; r++) begin
            be = (r == seedRounds) ? 4'hF : 4'(randomBits(4));
            data = (r == seedRounds) ? 32'h0 : randomBits(32);
            writeReg(anyOffset(lfsrAddr), be, data);
            merged = mergeBytes(modelLfsr, data, be);
            modelLfsr = (merged == 32'h0) ? 32'd1 : merged;
            // back-to-back reads, pre-step value each time
            repeat (readsPerSeed) begin
                readReg(anyOffset(lfsrAddr), modelLfsr, 0);
                modelLfsr = lfsrModelStep(modelLfsr);
            end
        end
        idle(2);

        // display writes, readback right behind the write
        for (int r = 0; r < displayRounds; r++) begin
            be = 4'(randomBits(4));
            data = randomBits(32);
            writeReg(anyOffset(displayAddr), be, data);
            modelDisplay = mergeBytes(modelDisplay, data, be);
            readReg(anyOffset(displayAddr), modelDisplay, 0);
            idle(2);
            checkDigits();
        end

        // clear, wait M cycles, read about M / ticksPerMs
        for (int r = 0; r < stopwatchRounds; r++) begin
            waitCycles = 10 + int'(randomBits(6));
            writeReg(stopwatchAddr, 4'hF, randomBits(32));
            idle(waitCycles - 1);
            readReg(stopwatchAddr, busDataT'(waitCycles / tbTicksPerMs), 1);
            idle(2);
        end

        // unmapped traffic must not disturb the mapped registers
        for (int r = 0; r < unmappedRounds; r++) begin
            readReg(unmappedAddr(), 32'h0, 0);
            writeReg(unmappedAddr(), 4'hF, randomBits(32));
            readReg(anyOffset(lfsrAddr), modelLfsr, 0);
            modelLfsr = lfsrModelStep(modelLfsr);
            readReg(anyOffset(displayAddr), modelDisplay, 0);
        end
        idle(2);
        checkDigits();

        failTotal = errorCount + peripheralBus_i.peripheralBusChecker_i.failCount;
        $display("checks: %0d, value errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, peripheralBus_i.peripheralBusChecker_i.failCount);
        if (failTotal == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
